// File: dv/resp_steer_vectors.txt
// Read responses, one per cycle
// Columns: resp_valid resp_tag resp_data, all hex
0 0 00000000
0 6 deadbeef
1 2 00000011
0 0 00000000
0 0 00000000
0 0 00000000
0 0 00000000
1 4 00000022
0 0 00000000
0 0 00000000
0 0 00000000
0 0 00000000
1 1 00000033
1 3 00000044
1 5 00000055
0 2 00000066
0 4 00000077
0 0 00000000
1 2 10000001
1 4 20000002
1 2 30000003
1 1 40000004
1 4 50000005
1 4 60000006
1 3 70000007
1 2 80000008
1 5 90000009
1 2 a000000a
1 4 b000000b
0 0 00000000
1 2 fffffff0
1 2 00000020
1 4 ffffffff
1 4 00000005
0 7 11111111
1 7 12345678
1 2 0000abcd
0 0 00000000
1 0 00000000
1 6 cafef00d
1 4 00001234
1 2 00005678
0 0 00000000

// File: vlog.f
logic/graph_cu_pkg.sv
logic/resp_tag_decode.sv
logic/struct_lane_demux.sv
logic/lane_accumulator.sv
logic/resp_steer_top.sv
dv/resp_steer_tb.sv

// File: dv/resp_steer_tb.sv
// Testbench for the read-response steering path
// Replays the vectors file one response per cycle and checks both lanes,
// the per-lane statistics and the sticky tag error against a routing model

module resp_steer_tb import graph_cu_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 10;
	localparam int PIPE_LATENCY = 4;
	localparam int FLUSH_CYCLES = 5;

	// Expected lane outputs for one input cycle
	typedef struct packed {
		logic                  edge_valid;
		logic [DATA_WIDTH-1:0] edge_data;
		logic                  graph_valid;
		logic [DATA_WIDTH-1:0] graph_data;
	} lane_exp_t;

	logic                   clock;
	logic                   rstn;
	logic                   resp_valid;
	logic [TAG_WIDTH-1:0]   resp_tag;
	logic [DATA_WIDTH-1:0]  resp_data;
	logic                   edge_dest_valid;
	logic [DATA_WIDTH-1:0]  edge_dest_data;
	logic                   graph_data_valid;
	logic [DATA_WIDTH-1:0]  graph_data;
	logic [COUNT_WIDTH-1:0] edge_dest_count;
	logic [DATA_WIDTH-1:0]  edge_dest_sum;
	logic [COUNT_WIDTH-1:0] graph_data_count;
	logic [DATA_WIDTH-1:0]  graph_data_sum;
	logic                   tag_error;

	// Stimulus from the vectors file
	logic                  vec_valid [$];
	logic [TAG_WIDTH-1:0]  vec_tag [$];
	logic [DATA_WIDTH-1:0] vec_data [$];
	logic                  vectors_loaded;

	// Model state
	lane_exp_t              exp_q [$];
	logic [COUNT_WIDTH-1:0] model_edge_count;
	logic [DATA_WIDTH-1:0]  model_edge_sum;
	logic [COUNT_WIDTH-1:0] model_graph_count;
	logic [DATA_WIDTH-1:0]  model_graph_sum;
	logic                   model_tag_error;
	int                     mismatch_count;
	int                     other_count;

	resp_steer_top dut (
		.clock            (clock),
		.rstn             (rstn),
		.resp_valid       (resp_valid),
		.resp_tag         (resp_tag),
		.resp_data        (resp_data),
		.edge_dest_valid  (edge_dest_valid),
		.edge_dest_data   (edge_dest_data),
		.graph_data_valid (graph_data_valid),
		.graph_data       (graph_data),
		.edge_dest_count  (edge_dest_count),
		.edge_dest_sum    (edge_dest_sum),
		.graph_data_count (graph_data_count),
		.graph_data_sum   (graph_data_sum),
		.tag_error        (tag_error)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// ----------------------------------------------------------------------
	// Checking helpers
	// ----------------------------------------------------------------------
	task automatic compare_signal(input string name, input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] expected);
		assert (got === expected) else begin
			$display("Mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
			mismatch_count++;
		end
	endtask

	// Lane 0 takes edge destinations, lane 1 vertex reads, rest dropped
	function automatic lane_exp_t route_word(input logic valid, input logic [TAG_WIDTH-1:0] tag,
			input logic [DATA_WIDTH-1:0] data);
		lane_exp_t result;
		result = '0;
		if (valid && tag == 3'd2) begin
			result.edge_valid = 1'b1;
			result.edge_data  = data;
		end else if (valid && tag == 3'd4) begin
			result.graph_valid = 1'b1;
			result.graph_data  = data;
		end
		return result;
	endfunction

	function automatic logic is_unknown_tag(input logic [TAG_WIDTH-1:0] tag);
		return (tag == 3'd0) || (tag == 3'd6) || (tag == 3'd7);
	endfunction

	task automatic check_stats();
		compare_signal("edge_dest_count", edge_dest_count, model_edge_count);
		compare_signal("edge_dest_sum", edge_dest_sum, model_edge_sum);
		compare_signal("graph_data_count", graph_data_count, model_graph_count);
		compare_signal("graph_data_sum", graph_data_sum, model_graph_sum);
	endtask

	// One falling edge: check the word that entered 4 cycles ago, then drive
	task automatic apply_cycle(input logic valid, input logic [TAG_WIDTH-1:0] tag,
			input logic [DATA_WIDTH-1:0] data);
		lane_exp_t expected;
		lane_exp_t routed;
		@(negedge clock);
		expected = exp_q.pop_front();
		compare_signal("edge_dest_valid", edge_dest_valid, expected.edge_valid);
		compare_signal("edge_dest_data", edge_dest_data, expected.edge_data);
		compare_signal("graph_data_valid", graph_data_valid, expected.graph_valid);
		compare_signal("graph_data", graph_data, expected.graph_data);
		compare_signal("tag_error", tag_error, model_tag_error);
		resp_valid = valid;
		resp_tag   = tag;
		resp_data  = data;
		routed = route_word(valid, tag, data);
		exp_q.push_back(routed);
		if (routed.edge_valid) begin
			model_edge_count = model_edge_count + 1'b1;
			model_edge_sum   = model_edge_sum + data;
		end
		if (routed.graph_valid) begin
			model_graph_count = model_graph_count + 1'b1;
			model_graph_sum   = model_graph_sum + data;
		end
		if (valid && is_unknown_tag(tag))
			model_tag_error = 1'b1;
	endtask

	// Skips comment lines, keeps lines with three hex fields
	task automatic load_vectors();
		int    fd;
		int    fields;
		string line;
		logic [DATA_WIDTH-1:0] v;
		logic [DATA_WIDTH-1:0] t;
		logic [DATA_WIDTH-1:0] d;
		fd = $fopen("dv/resp_steer_vectors.txt", "r");
		if (fd == 0)
			return;
		while ($fgets(line, fd)) begin
			if (line.len() > 0 && line[0] != "/") begin
				fields = $sscanf(line, "%h %h %h", v, t, d);
				if (fields == 3) begin
					vec_valid.push_back(v[0]);
					vec_tag.push_back(t[TAG_WIDTH-1:0]);
					vec_data.push_back(d);
				end
			end
		end
		$fclose(fd);
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial begin
		clock             = 1'b0;
		rstn              = 1'b0;
		resp_valid        = 1'b0;
		resp_tag          = '0;
		resp_data         = '0;
		vectors_loaded    = 1'b0;
		mismatch_count    = 0;
		other_count       = 0;
		model_edge_count  = '0;
		model_edge_sum    = '0;
		model_graph_count = '0;
		model_graph_sum   = '0;
		model_tag_error   = 1'b0;
		load_vectors();
		if (vec_valid.size() == 0) begin
			$display("Could not read any vectors from dv/resp_steer_vectors.txt");
			other_count++;
			$display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
			$display("TEST FAIL");
			$finish;
		end else begin
			vectors_loaded = 1'b1;
			repeat (RESET_CYCLES) @(posedge clock);
			@(negedge clock);
			rstn = 1'b1;
			// Idle cycle out of reset, everything must still read zero
			@(negedge clock);
			compare_signal("edge_dest_valid", edge_dest_valid, '0);
			compare_signal("edge_dest_data", edge_dest_data, '0);
			compare_signal("graph_data_valid", graph_data_valid, '0);
			compare_signal("graph_data", graph_data, '0);
			compare_signal("tag_error", tag_error, '0);
			check_stats();
			// Pipeline holds idle words at start
			repeat (PIPE_LATENCY) exp_q.push_back('0);
			for (int i = 0; i < vec_valid.size(); i++)
				apply_cycle(vec_valid[i], vec_tag[i], vec_data[i]);
			// Drain lanes, statistics settle one cycle later
			repeat (FLUSH_CYCLES) apply_cycle(1'b0, '0, '0);
			check_stats();
			$display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
			if (mismatch_count == 0 && other_count == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
			$finish;
		end
	end

	// Watchdog, sized from the vector count
	initial begin
		wait (vectors_loaded);
		#((vec_valid.size() + 20) * CLK_PERIOD);
		$display("Simulation ran too long, stopped by the watchdog");
		other_count++;
		$display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: logic/resp_steer_top.sv
// Read-response steering path
// Decode, lane demux and per-lane statistics for memory responses of the
// graph compute unit; lane outputs trail the input strobe by 4 cycles

module resp_steer_top import graph_cu_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   resp_valid,
	input  logic [TAG_WIDTH-1:0]   resp_tag,
	input  logic [DATA_WIDTH-1:0]  resp_data,
	output logic                   edge_dest_valid,
	output logic [DATA_WIDTH-1:0]  edge_dest_data,
	output logic                   graph_data_valid,
	output logic [DATA_WIDTH-1:0]  graph_data,
	output logic [COUNT_WIDTH-1:0] edge_dest_count,
	output logic [DATA_WIDTH-1:0]  edge_dest_sum,
	output logic [COUNT_WIDTH-1:0] graph_data_count,
	output logic [DATA_WIDTH-1:0]  graph_data_sum,
	output logic                   tag_error
);

	// Decode to demux
	logic                  dec_valid;
	array_struct_type      dec_struct;
	logic [DATA_WIDTH-1:0] dec_data;

	// Demux lanes
	logic [BUS_WIDTH-1:0]  lane_valid;
	logic [DATA_WIDTH-1:0] lane_data [BUS_WIDTH];

	// ----------------------------------------------------------------------
	// Datapath stages
	// ----------------------------------------------------------------------
	resp_tag_decode u_decode (
		.clock      (clock),
		.rstn       (rstn),
		.resp_valid (resp_valid),
		.resp_tag   (resp_tag),
		.resp_data  (resp_data),
		.dec_valid  (dec_valid),
		.dec_struct (dec_struct),
		.dec_data   (dec_data),
		.tag_error  (tag_error)
	);

	struct_lane_demux #(
		.payload_t (logic [DATA_WIDTH-1:0])
	) u_demux (
		.clock      (clock),
		.rstn       (rstn),
		.enabled_in (dec_valid),
		.sel_in     (dec_struct),
		.data_in    (dec_data),
		.lane_valid (lane_valid),
		.lane_data  (lane_data)
	);

	// Lane outputs by index
	assign edge_dest_valid  = lane_valid[LANE_EDGE_DEST];
	assign edge_dest_data   = lane_data[LANE_EDGE_DEST];
	assign graph_data_valid = lane_valid[LANE_GRAPH_DATA];
	assign graph_data       = lane_data[LANE_GRAPH_DATA];

	// ----------------------------------------------------------------------
	// Statistics, one per lane
	// ----------------------------------------------------------------------
	lane_accumulator u_acc_edge_dest (
		.clock      (clock),
		.rstn       (rstn),
		.lane_valid (lane_valid[LANE_EDGE_DEST]),
		.lane_data  (lane_data[LANE_EDGE_DEST]),
		.word_count (edge_dest_count),
		.word_sum   (edge_dest_sum)
	);

	lane_accumulator u_acc_graph_data (
		.clock      (clock),
		.rstn       (rstn),
		.lane_valid (lane_valid[LANE_GRAPH_DATA]),
		.lane_data  (lane_data[LANE_GRAPH_DATA]),
		.word_count (graph_data_count),
		.word_sum   (graph_data_sum)
	);

endmodule

// File: logic/lane_accumulator.sv
// Per-lane word statistics
// Counts the words delivered on one demux lane and keeps their running sum,
// both wrapping at their register width

module lane_accumulator import graph_cu_pkg::*; (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   lane_valid,
	input  logic [DATA_WIDTH-1:0]  lane_data,
	output logic [COUNT_WIDTH-1:0] word_count,
	output logic [DATA_WIDTH-1:0]  word_sum
);

	logic [COUNT_WIDTH-1:0] count_next;
	logic [DATA_WIDTH-1:0]  sum_next;

	// ----------------------------------------------------------------------
	// Next-state arithmetic
	// ----------------------------------------------------------------------
	always_comb begin
		count_next = word_count;
		sum_next   = word_sum;
		if (lane_valid) begin
			// Both wrap modulo their register width
			count_next = word_count + 1'b1;
			sum_next   = word_sum + lane_data;
		end
	end

	// ----------------------------------------------------------------------
	// Statistics registers
	// ----------------------------------------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			word_count <= '0;
			word_sum   <= '0;
		end else begin
			word_count <= count_next;
			word_sum   <= sum_next;
		end
	end

	// Count only moves on the cycle after a lane word
	a_count_hold : assert property (@(posedge clock) disable iff (!rstn)
		!lane_valid |=> $stable(word_count));

endmodule

// File: logic/struct_lane_demux.sv
// Structure-type lane demux
// Steers a payload onto the lane owned by its structure type: edge destination
// indices to one lane, vertex graph data to the other, everything else dropped.
// Three register stages, input, enable-gated hold and output

module struct_lane_demux import graph_cu_pkg::*; #(
	parameter type payload_t = logic [DATA_WIDTH-1:0]
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled_in,
	input  array_struct_type     sel_in,
	input  payload_t             data_in,
	output logic [BUS_WIDTH-1:0] lane_valid,
	output payload_t             lane_data [BUS_WIDTH]
);

	logic             enabled;
	array_struct_type sel_internal;
	payload_t         data_internal;
	array_struct_type sel_held;
	payload_t         data_held;
	logic [BUS_WIDTH-1:0] lane_valid_next;
	payload_t             lane_data_next [BUS_WIDTH];

	// ----------------------------------------------------------------------
	// Stage 1, input capture
	// ----------------------------------------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled       <= 1'b0;
			sel_internal  <= STRUCT_INVALID;
			data_internal <= '0;
		end else begin
			enabled       <= enabled_in;
			sel_internal  <= sel_in;
			data_internal <= data_in;
		end
	end

	// ----------------------------------------------------------------------
	// Stage 2, keep only enabled words
	// ----------------------------------------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sel_held  <= STRUCT_INVALID;
			data_held <= '0;
		end else if (enabled) begin
			sel_held  <= sel_internal;
			data_held <= data_internal;
		end else begin
			// Idle cycle, present nothing to the decoder
			sel_held  <= STRUCT_INVALID;
			data_held <= '0;
		end
	end

	// Lane decoder, unused lanes and types stay zero
	always_comb begin
		lane_valid_next = '0;
		for (int i = 0; i < BUS_WIDTH; i++)
			lane_data_next[i] = '0;
		case (sel_held)
			EDGE_ARRAY_DEST : begin
				lane_valid_next[LANE_EDGE_DEST] = 1'b1;
				lane_data_next[LANE_EDGE_DEST]  = data_held;
			end
			READ_GRAPH_DATA : begin
				lane_valid_next[LANE_GRAPH_DATA] = 1'b1;
				lane_data_next[LANE_GRAPH_DATA]  = data_held;
			end
			default : ;
		endcase
	end

	// ----------------------------------------------------------------------
	// Stage 3, output register
	// ----------------------------------------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lane_valid <= '0;
			for (int i = 0; i < BUS_WIDTH; i++)
				lane_data[i] <= '0;
		end else begin
			lane_valid <= lane_valid_next;
			lane_data  <= lane_data_next;
		end
	end

	// Each word lands on one lane only
	a_one_lane : assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(lane_valid));

endmodule

// File: logic/resp_tag_decode.sv
// Response tag decode stage
// Registers each memory response and maps its raw tag onto the structure type;
// unknown codes on a valid word raise a sticky error flag

module resp_tag_decode import graph_cu_pkg::*; (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  resp_valid,
	input  logic [TAG_WIDTH-1:0]  resp_tag,
	input  logic [DATA_WIDTH-1:0] resp_data,
	output logic                  dec_valid,
	output array_struct_type      dec_struct,
	output logic [DATA_WIDTH-1:0] dec_data,
	output logic                  tag_error
);

	array_struct_type tag_struct;
	logic             tag_known;

	// Combinational tag lookup
	always_comb begin
		tag_known  = 1'b1;
		tag_struct = STRUCT_INVALID;
		case (resp_tag)
			TAG_EDGE_SRC    : tag_struct = EDGE_ARRAY_SRC;
			TAG_EDGE_DEST   : tag_struct = EDGE_ARRAY_DEST;
			TAG_EDGE_WEIGHT : tag_struct = EDGE_ARRAY_WEIGHT;
			TAG_GRAPH_READ  : tag_struct = READ_GRAPH_DATA;
			TAG_GRAPH_WRITE : tag_struct = WRITE_GRAPH_DATA;
			default         : tag_known  = 1'b0;
		endcase
	end

	// Valid, type and payload registers; a dropped or idle cycle leaves STRUCT_INVALID
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			dec_valid  <= 1'b0;
			dec_struct <= STRUCT_INVALID;
			dec_data   <= '0;
			tag_error  <= 1'b0;
		end else begin
			dec_valid  <= resp_valid && tag_known;
			dec_struct <= (resp_valid && tag_known) ? tag_struct : STRUCT_INVALID;
			dec_data   <= resp_data;
			// Sticky until reset
			if (resp_valid && !tag_known)
				tag_error <= 1'b1;
		end
	end

	// A valid word always carries a real structure type downstream
	a_valid_has_type : assert property (@(posedge clock) disable iff (!rstn)
		dec_valid |-> dec_struct != STRUCT_INVALID);

endmodule

// File: logic/graph_cu_pkg.sv
// Shared definitions for the graph compute unit read-response path
// Memory structure types, raw tag codes, widths and demux lane indices

package graph_cu_pkg;

	// ----------------------------------------------------------------------
	// Memory structures a response word can belong to
	// ----------------------------------------------------------------------
	typedef enum logic [2:0] {
		STRUCT_INVALID,
		EDGE_ARRAY_SRC,
		EDGE_ARRAY_DEST,
		EDGE_ARRAY_WEIGHT,
		READ_GRAPH_DATA,
		WRITE_GRAPH_DATA
	} array_struct_type;

	// ----------------------------------------------------------------------
	// Raw response tag as returned by the memory port
	// ----------------------------------------------------------------------
	localparam int TAG_WIDTH = 3;

	// Codes 0, 6 and 7 are not assigned
	localparam logic [TAG_WIDTH-1:0] TAG_EDGE_SRC    = 3'd1;
	localparam logic [TAG_WIDTH-1:0] TAG_EDGE_DEST   = 3'd2;
	localparam logic [TAG_WIDTH-1:0] TAG_EDGE_WEIGHT = 3'd3;
	localparam logic [TAG_WIDTH-1:0] TAG_GRAPH_READ  = 3'd4;
	localparam logic [TAG_WIDTH-1:0] TAG_GRAPH_WRITE = 3'd5;

	// ----------------------------------------------------------------------
	// Datapath widths and lane map
	// ----------------------------------------------------------------------
	localparam int DATA_WIDTH  = 32;
	localparam int COUNT_WIDTH = 16;
	localparam int BUS_WIDTH   = 2;

	// Edge destination indices on lane 0, vertex data on lane 1
	localparam int LANE_EDGE_DEST  = 0;
	localparam int LANE_GRAPH_DATA = 1;

endpackage
